// ==== logic/sha256_compress.sv ====
//==================================================
// Compression datapath, one round per enabled cycle
// Init and update are single-cycle pulses
//==================================================
`timescale 1ns/10ps
`include "sha256_config.svh"

module sha256_compress
  import sha256_pkg::*;
(
  input  logic                          i_clk,
  input  logic                          i_rst,
  input  logic [31:0]                   i_w,
  input  logic [5:0]                    i_round_idx,
  input  logic                          i_round_en,
  input  logic                          i_hv_init,
  input  logic                          i_hv_update,
  output logic [`SHA256_DIGEST_BITS-1:0] o_digest
);

  // v[0] is A through v[7] which is H
  logic [7:0][31:0] v;
  logic [7:0][31:0] hv;  // Running hash words
  logic [31:0]      t1, t2;

  always_comb begin
    t1 = v[7] + big_sig1(v[4]) + ch(v[4], v[5], v[6]) + SHA256_K[i_round_idx] + i_w;
    t2 = big_sig0(v[0]) + maj(v[0], v[1], v[2]);
  end

  always_ff @(posedge i_clk) begin
    if (i_rst || i_hv_init) begin
      for (int i = 0; i < 8; i++) begin
        hv[i] <= SHA256_IV[i];
        v[i]  <= SHA256_IV[i];
      end
    end else if (i_hv_update) begin
      // Next block starts from the updated hash words
      for (int i = 0; i < 8; i++) begin
        hv[i] <= hv[i] + v[i];
        v[i]  <= hv[i] + v[i];
      end
    end else if (i_round_en) begin
      v[7] <= v[6];
      v[6] <= v[5];
      v[5] <= v[4];
      v[4] <= v[3] + t1;  // E takes D plus T1
      v[3] <= v[2];
      v[2] <= v[1];
      v[1] <= v[0];
      v[0] <= t1 + t2;
    end
  end

  // Words go back to stream order so digest byte 0 is in bits 7:0
  always_comb begin
    for (int i = 0; i < 8; i++)
      o_digest[32*i +: 32] = bswap32(hv[i]);
  end

endmodule

// ==== logic/sha256_config.svh ====
//==================================================
// Fixed SHA-256 sizes, not meant to be changed
// Beat width and block width are the same 64 bytes
//==================================================
`ifndef SHA256_CONFIG_SVH
`define SHA256_CONFIG_SVH

// Compression rounds run for each 512-bit block
`define SHA256_ROUNDS 64

`define SHA256_BLOCK_BYTES 64  // Bytes per input beat and per block
`define SHA256_DIGEST_BITS 256 // Digest width, byte 0 in the lowest lane

`endif

// ==== logic/sha256_engine.sv ====
//==================================================
// SHA-256 engine over a 512-bit valid/ready stream
// Digest is held until i_digest_rdy is seen
//==================================================
`timescale 1ns/10ps
`include "sha256_config.svh"

module sha256_engine
  import sha256_pkg::*;
(
  input  logic                          i_clk,
  input  logic                          i_rst,
  input  sha256_beat_t                  i_beat,
  input  logic                          i_beat_val,
  output logic                          o_beat_rdy,
  output logic [`SHA256_DIGEST_BITS-1:0] o_digest,
  output logic                          o_digest_val,
  input  logic                          i_digest_rdy
);

  logic          load;
  sha256_block_t block;
  logic          round_en;
  logic [5:0]    round_idx;
  logic          hv_init;
  logic          hv_update;
  logic [31:0]   w;  // Schedule word for the current round

  sha256_msg_ctrl u_ctrl (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_beat       (i_beat),
    .i_beat_val   (i_beat_val),
    .o_beat_rdy   (o_beat_rdy),
    .i_digest_rdy (i_digest_rdy),
    .o_digest_val (o_digest_val),
    .o_load       (load),
    .o_block      (block),
    .o_round_en   (round_en),
    .o_round_idx  (round_idx),
    .o_hv_init    (hv_init),
    .o_hv_update  (hv_update)
  );

  sha256_schedule u_sched (
    .i_clk      (i_clk),
    .i_load     (load),
    .i_block    (block),
    .i_round_en (round_en),
    .o_w        (w)
  );

  sha256_compress u_comp (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_w         (w),
    .i_round_idx (round_idx),
    .i_round_en  (round_en),
    .i_hv_init   (hv_init),
    .i_hv_update (hv_update),
    .o_digest    (o_digest)
  );

endmodule

// ==== logic/sha256_msg_ctrl.sv ====
//==================================================
// One message at a time, zero-byte messages unsupported
// Length counter wraps past 2^61 bytes
// Input is stalled while a block is compressed
//==================================================
`timescale 1ns/10ps
`include "sha256_config.svh"

module sha256_msg_ctrl
  import sha256_pkg::*;
(
  input  logic          i_clk,
  input  logic          i_rst,
  input  sha256_beat_t  i_beat,
  input  logic          i_beat_val,
  output logic          o_beat_rdy,
  input  logic          i_digest_rdy,
  output logic          o_digest_val,
  output logic          o_load,
  output sha256_block_t o_block,
  output logic          o_round_en,
  output logic [5:0]    o_round_idx,
  output logic          o_hv_init,
  output logic          o_hv_update
);

  sha256_state_t state, state_nxt;
  logic [63:0]   bit_len;   // Message length in bits so far
  logic          msg_end;   // The eop beat has been taken
  logic          pad_pend;  // A padding-only block is still owed
  logic          pad_full;  // The owed block also carries the 0x80 marker
  logic          accept;
  logic          load_pad;
  logic          fits;      // Marker and length both fit in the eop beat
  logic [6:0]    n_bytes;
  logic [63:0]   len_base, len_tot;
  logic [8*`SHA256_BLOCK_BYTES-1:0] dat_pad;
  sha256_block_t blk_beat, blk_pad;

  assign accept   = i_beat_val & o_beat_rdy;
  assign load_pad = (state == UPDATE) & pad_pend;

  // Strobes follow straight from the registered state
  assign o_load       = accept | load_pad;
  assign o_hv_init    = accept & (state == IDLE);
  assign o_round_en   = (state == ROUNDS);
  assign o_digest_val = (state == FINAL);

  always_comb begin
    n_bytes  = (i_beat.mod == 6'd0) ? 7'd64 : {1'b0, i_beat.mod};
    fits     = (i_beat.mod != 6'd0) && (i_beat.mod <= 6'(`SHA256_BLOCK_BYTES - 9));
    len_base = (state == IDLE || i_beat.sop) ? 64'd0 : bit_len;  // sop restarts the count
    len_tot  = len_base + (i_beat.eop ? {54'd0, n_bytes, 3'd0}
                                      : 64'(`SHA256_BLOCK_BYTES * 8));
    // Bytes past the end are cleared and the first one takes the marker
    for (int k = 0; k < `SHA256_BLOCK_BYTES; k++) begin
      if (!i_beat.eop || k < n_bytes)
        dat_pad[8*k +: 8] = i_beat.dat[8*k +: 8];
      else if (k == n_bytes)
        dat_pad[8*k +: 8] = 8'h80;
      else
        dat_pad[8*k +: 8] = 8'h00;
    end
    for (int i = 0; i < 16; i++)
      blk_beat.w[i] = bswap32(dat_pad[32*i +: 32]);
    if (i_beat.eop && fits) begin
      blk_beat.w[14] = len_tot[63:32];  // Length goes big-endian into the last two words
      blk_beat.w[15] = len_tot[31:0];
    end
    blk_pad       = '0;
    blk_pad.w[0]  = pad_full ? 32'h8000_0000 : 32'h0;
    blk_pad.w[14] = bit_len[63:32];
    blk_pad.w[15] = bit_len[31:0];
    o_block = load_pad ? blk_pad : blk_beat;
  end

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE:   if (accept) state_nxt = ROUNDS;
      ROUNDS: if (o_round_idx == 6'(`SHA256_ROUNDS - 1)) state_nxt = UPDATE;
      UPDATE: begin
        if (pad_pend)
          state_nxt = ROUNDS;  // Padding-only block goes right away
        else if (msg_end)
          state_nxt = FINAL;
        else if (accept)
          state_nxt = ROUNDS;
      end
      FINAL:  if (i_digest_rdy) state_nxt = IDLE;
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state       <= IDLE;
      o_round_idx <= 6'd0;
      o_beat_rdy  <= 1'b0;
      o_hv_update <= 1'b0;
      bit_len     <= 64'd0;
      msg_end     <= 1'b0;
      pad_pend    <= 1'b0;
      pad_full    <= 1'b0;
    end else begin
      state       <= state_nxt;
      o_round_idx <= (state == ROUNDS) ? o_round_idx + 6'd1 : 6'd0;  // Wraps after 63
      // Ready is registered so it shows up one cycle after reset
      o_beat_rdy  <= (state_nxt == IDLE) | ((state_nxt == UPDATE) & ~msg_end);
      o_hv_update <= (state == ROUNDS) && (o_round_idx == 6'(`SHA256_ROUNDS - 1));
      if (accept) begin
        bit_len  <= len_tot;
        msg_end  <= i_beat.eop;
        pad_pend <= i_beat.eop & ~fits;
        pad_full <= i_beat.eop & (i_beat.mod == 6'd0);  // Beat was full, marker not placed yet
      end else if (load_pad) begin
        pad_pend <= 1'b0;
      end
    end
  end

endmodule

// ==== logic/sha256_pkg.sv ====
//==================================================
// Types, constants and bit functions for SHA-256
// All words inside the hash are big-endian values
//==================================================
`include "sha256_config.svh"

package sha256_pkg;

  // One input beat, byte 0 of the message slice sits in dat[7:0]
  typedef struct packed {
    logic [8*`SHA256_BLOCK_BYTES-1:0] dat;
    logic                             sop;  // First beat of a message
    logic                             eop;  // Last beat of a message
    logic [5:0]                       mod;  // Valid bytes on eop, 0 means all 64
  } sha256_beat_t;

  // Block as the schedule sees it, w[0] is the first word of the message
  typedef struct packed {
    logic [15:0][31:0] w;
  } sha256_block_t;

  typedef enum logic [1:0] {
    IDLE,   // Waiting for the sop beat
    ROUNDS, // One compression round per clock
    UPDATE, // Hash words take the working variables
    FINAL   // Digest held until it is taken
  } sha256_state_t;

  // Round constants, index 0 first
  localparam logic [0:`SHA256_ROUNDS-1][31:0] SHA256_K = {
    32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
    32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
    32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
    32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
    32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
    32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
    32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
    32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
    32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
    32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
    32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
    32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
    32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
    32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
    32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
    32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
  };

  // Initial hash words H0 to H7
  localparam logic [0:7][31:0] SHA256_IV = {
    32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
    32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
  };

  // Rotate right by a constant amount
  function automatic logic [31:0] rotr32(input logic [31:0] x, input int n);
    return (x >> n) | (x << (32 - n));
  endfunction

  // Swaps little-endian stream bytes into a big-endian word and back
  function automatic logic [31:0] bswap32(input logic [31:0] x);
    return {x[7:0], x[15:8], x[23:16], x[31:24]};
  endfunction

  function automatic logic [31:0] big_sig0(input logic [31:0] x);
    return rotr32(x, 2) ^ rotr32(x, 13) ^ rotr32(x, 22);
  endfunction

  function automatic logic [31:0] big_sig1(input logic [31:0] x);
    return rotr32(x, 6) ^ rotr32(x, 11) ^ rotr32(x, 25);
  endfunction

  // The small sigmas mix a shift in, not only rotations
  function automatic logic [31:0] small_sig0(input logic [31:0] x);
    return rotr32(x, 7) ^ rotr32(x, 18) ^ (x >> 3);
  endfunction

  function automatic logic [31:0] small_sig1(input logic [31:0] x);
    return rotr32(x, 17) ^ rotr32(x, 19) ^ (x >> 10);
  endfunction

  // E picks F or G bit by bit
  function automatic logic [31:0] ch(input logic [31:0] e, input logic [31:0] f,
                                     input logic [31:0] g);
    return (e & f) ^ (~e & g);
  endfunction

  // Majority vote of A, B and C per bit
  function automatic logic [31:0] maj(input logic [31:0] a, input logic [31:0] b,
                                      input logic [31:0] c);
    return (a & b) ^ (a & c) ^ (b & c);
  endfunction

endpackage

// ==== logic/sha256_schedule.sv ====
//==================================================
// Message schedule window, no reset
// Output is valid the cycle after a load
//==================================================
`timescale 1ns/10ps

module sha256_schedule
  import sha256_pkg::*;
(
  input  logic          i_clk,
  input  logic          i_load,
  input  sha256_block_t i_block,
  input  logic          i_round_en,
  output logic [31:0]   o_w
);

  logic [15:0][31:0] win;  // win[0] is the word used this round
  logic [31:0]       w_nxt;

  // New word sixteen rounds ahead of the current one
  assign w_nxt = small_sig1(win[14]) + win[9] + small_sig0(win[1]) + win[0];

  always_ff @(posedge i_clk) begin
    if (i_load) begin
      win <= i_block.w;
    end else if (i_round_en) begin
      for (int i = 0; i < 15; i++)
        win[i] <= win[i+1];  // Slide down by one word
      win[15] <= w_nxt;
    end
  end

  assign o_w = win[0];

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Builds the SHA-256 testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f verilog.f --top-module tb_sha256 > build.log 2>&1 \
  && ./obj_dir/Vtb_sha256 > sim.log 2>&1 \
  && ! grep -q "TESTBENCH FAILED" sim.log \
  && echo "Simulation passed, see sim.log" \
  || { echo "Simulation failed, see build.log and sim.log"; exit 1; }

// ==== tb/tb_sha256_model.svh ====
//==================================================
// Reference SHA-256 for the testbench, bytes in message order
// Constants come from prime roots, call build_constants first
// Digest byte 0 is returned in bits 7:0
//==================================================
`ifndef TB_SHA256_MODEL_SVH
`define TB_SHA256_MODEL_SVH

logic [31:0] k_tab[64];  // Cube root fractions of the first 64 primes
logic [31:0] iv_tab[8];  // Square root fractions of the first 8 primes

function automatic logic [127:0] power_of(input logic [127:0] x, input int n);
  return (n == 2) ? x * x : x * x * x;
endfunction

// Largest x with x^n <= p * 2^(32n), low 32 bits are the fraction
function automatic logic [31:0] root_frac(input int p, input int n);
  logic [127:0] x;
  logic [127:0] lim;
  real          est;
  est = (n == 2) ? $sqrt(p) : $pow(p, 1.0 / 3.0);
  x   = 128'(longint'(est * 4294967296.0));  // Close guess, exact after the steps below
  lim = 128'(p) << (32 * n);
  for (int i = 0; i < 4; i++) begin
    if (power_of(x + 1, n) <= lim)
      x = x + 1;
    else if (power_of(x, n) > lim)
      x = x - 1;
  end
  return x[31:0];
endfunction

task automatic build_constants();
  int p;
  int cnt;
  bit is_prime;
  p   = 1;
  cnt = 0;
  while (cnt < 64) begin
    p++;
    is_prime = 1'b1;
    for (int d = 2; d * d <= p; d++)
      if (p % d == 0) is_prime = 1'b0;
    if (is_prime) begin
      k_tab[cnt] = root_frac(p, 3);
      if (cnt < 8) iv_tab[cnt] = root_frac(p, 2);
      cnt++;
    end
  end
endtask

function automatic logic [31:0] rot_r(input logic [31:0] x, input int s);
  return (x >> s) | (x << (32 - s));
endfunction

function automatic logic [255:0] expected_digest(input logic [7:0] data[$]);
  logic [7:0]   pad_q[$];
  logic [63:0]  nbits;
  logic [31:0]  h[8];
  logic [31:0]  a[8];
  logic [31:0]  w[64];
  logic [31:0]  s0, s1, t1, t2;
  logic [255:0] dig;
  int           base;
  pad_q = data;
  nbits = 64'(data.size()) * 8;
  pad_q.push_back(8'h80);
  while (pad_q.size() % 64 != 56)
    pad_q.push_back(8'h00);
  for (int i = 7; i >= 0; i--)
    pad_q.push_back(nbits[8*i +: 8]);  // Length field, most significant byte first
  for (int i = 0; i < 8; i++)
    h[i] = iv_tab[i];
  for (int blk = 0; blk < pad_q.size() / 64; blk++) begin
    for (int t = 0; t < 64; t++) begin
      base = 64 * blk + 4 * t;
      if (t < 16) begin
        w[t] = {pad_q[base], pad_q[base + 1], pad_q[base + 2], pad_q[base + 3]};
      end else begin
        s0   = rot_r(w[t-15], 7) ^ rot_r(w[t-15], 18) ^ (w[t-15] >> 3);
        s1   = rot_r(w[t-2], 17) ^ rot_r(w[t-2], 19) ^ (w[t-2] >> 10);
        w[t] = w[t-16] + s0 + w[t-7] + s1;
      end
    end
    a = h;
    for (int t = 0; t < 64; t++) begin
      s1 = rot_r(a[4], 6) ^ rot_r(a[4], 11) ^ rot_r(a[4], 25);
      t1 = a[7] + s1 + ((a[4] & a[5]) ^ (~a[4] & a[6])) + k_tab[t] + w[t];
      s0 = rot_r(a[0], 2) ^ rot_r(a[0], 13) ^ rot_r(a[0], 22);
      t2 = s0 + ((a[0] & a[1]) ^ (a[0] & a[2]) ^ (a[1] & a[2]));
      for (int j = 7; j > 0; j--)
        a[j] = a[j-1];
      a[4] = a[4] + t1;  // Old D plus T1
      a[0] = t1 + t2;
    end
    for (int j = 0; j < 8; j++)
      h[j] = h[j] + a[j];
  end
  for (int i = 0; i < 32; i++)
    dig[8*i +: 8] = h[i/4][8*(3 - i%4) +: 8];
  return dig;
endfunction

`endif

// ==== tb/tb_sha256.sv ====
//==================================================
// Random SHA-256 messages checked against a reference model
// Covers padding cases, back-pressure and mid-message reset
// Run is cut off after 80000 cycles
//==================================================
`timescale 1ns/10ps
`include "sha256_config.svh"

module tb_sha256
  import sha256_pkg::*;
();

  localparam int MAX_CYCLES = 80000;  // 200 messages, 5 blocks of 70 cycles, plus hold time
  localparam logic [255:0] ABC_BE =
    256'hba7816bf_8f01cfea_414140de_5dae2223_b00361a3_96177a9c_b410ff61_f20015ad;

  logic                           clk;
  logic                           rst;
  sha256_beat_t                   beat;
  logic                           beat_val;
  logic                           beat_rdy;
  logic [`SHA256_DIGEST_BITS-1:0] digest;
  logic                           digest_val;
  logic                           digest_rdy;

  logic [7:0]   msg[$];         // Bytes of the message under test
  logic [255:0] abc_exp;        // Standard digest in stream byte order
  int           errors = 0;
  int           n_msgs = 0;
  int           n_digests = 0;  // Times digest valid went high
  logic         val_seen;       // Digest valid on the previous falling edge
  int           cycles = 0;

  `include "tb_sha256_model.svh"

  sha256_engine dut (
    .i_clk        (clk),
    .i_rst        (rst),
    .i_beat       (beat),
    .i_beat_val   (beat_val),
    .o_beat_rdy   (beat_rdy),
    .o_digest     (digest),
    .o_digest_val (digest_val),
    .i_digest_rdy (digest_rdy)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Run stopped at cycle %0d because the DUT did not finish in time", cycles);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // Sampled on the falling edge, between drive and capture
  always @(negedge clk) begin
    if (rst) begin
      val_seen <= 1'b0;
    end else begin
      if (digest_val && !val_seen)
        n_digests <= n_digests + 1;  // A new digest is on offer
      val_seen <= digest_val;
    end
  end

  task automatic make_msg(input int len);
    msg.delete();
    for (int i = 0; i < len; i++)
      msg.push_back(8'($urandom()));
  endtask

  // Sends the first count beats of msg, with idle gaps in between
  task automatic send_beats(input int count);
    sha256_beat_t b;
    int           nb;
    nb = (msg.size() + 63) / 64;
    for (int i = 0; i < count; i++) begin
      repeat ($urandom_range(1, 4)) @(posedge clk);
      for (int k = 0; k < 16; k++)
        b.dat[32*k +: 32] = $urandom();  // Lanes past the end hold junk
      for (int k = 0; k < 64 && 64 * i + k < msg.size(); k++)
        b.dat[8*k +: 8] = msg[64*i + k];
      b.sop    = (i == 0);
      b.eop    = (i == nb - 1);
      b.mod    = b.eop ? 6'(msg.size() % 64) : 6'd0;
      beat     <= b;
      beat_val <= 1'b1;
      @(negedge clk);
      while (!beat_rdy) begin
        if (digest_val) begin
          errors++;
          $display("Digest valid went high while message beats were still being sent");
        end
        @(negedge clk);
      end
      @(posedge clk);  // Beat transfers on this edge
      beat_val <= 1'b0;
    end
  endtask

  task automatic take_digest(input string name, input logic [255:0] exp);
    @(negedge clk);
    while (!digest_val)
      @(negedge clk);
    if (digest !== exp) begin
      errors++;
      $display("CHECK FAILED %s expected %h actual %h", name, exp, digest);
    end
    repeat ($urandom_range(0, 8)) begin  // Consumer not ready yet
      @(negedge clk);
      if (!digest_val) begin
        errors++;
        $display("Digest valid dropped before %s was accepted", name);
      end else if (digest !== exp) begin
        errors++;
        $display("CHECK FAILED %s_hold expected %h actual %h", name, exp, digest);
      end
      if (beat_rdy) begin
        errors++;
        $display("Beat ready was high while the digest of %s was waiting", name);
      end
    end
    @(posedge clk);
    digest_rdy <= 1'b1;
    @(posedge clk);
    digest_rdy <= 1'b0;
    @(negedge clk);
    if (digest_val) begin
      errors++;
      $display("Digest valid stayed high after the digest of %s was accepted", name);
    end
  endtask

  task automatic run_message(input string name, input int len);
    logic [255:0] exp;
    make_msg(len);
    exp = expected_digest(msg);
    send_beats((len + 63) / 64);
    take_digest(name, exp);
    n_msgs++;
  endtask

  initial begin
    void'($urandom(85256));
    clk        = 1'b0;
    rst        = 1'b1;
    beat       = '0;
    beat_val   = 1'b0;
    digest_rdy = 1'b0;
    build_constants();
    for (int i = 0; i < 32; i++)
      abc_exp[8*i +: 8] = ABC_BE[8*(31 - i) +: 8];  // First digest byte to the low lane
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    if (beat_rdy || digest_val) begin
      errors++;
      $display("Ready or digest valid was high directly after reset");
    end

    msg.delete();
    msg.push_back(8'h61);
    msg.push_back(8'h62);
    msg.push_back(8'h63);
    if (expected_digest(msg) !== abc_exp) begin
      errors++;
      $display("Reference model does not give the standard digest of abc");
    end
    send_beats(1);
    take_digest("abc_vector", abc_exp);
    n_msgs++;

    for (int i = 0; i < 60; i++)
      run_message("single_fit", $urandom_range(1, 55));
    for (int i = 0; i < 60; i++)
      run_message("single_pad", $urandom_range(56, 64));  // 64 bytes gives mod 0
    for (int i = 0; i < 60; i++)
      run_message("multi_beat", 64 * $urandom_range(1, 3) + $urandom_range(1, 64));

    // Reset lands somewhere inside a message that never finishes
    for (int i = 0; i < 5; i++) begin
      make_msg(128 + $urandom_range(1, 128));
      send_beats(1);
      repeat ($urandom_range(2, 80)) @(posedge clk);
      rst <= 1'b1;
      repeat (4) @(posedge clk);
      rst <= 1'b0;
      run_message("after_reset", 64 * $urandom_range(0, 2) + $urandom_range(1, 64));
    end

    repeat (2) @(negedge clk);
    if (n_digests != n_msgs) begin
      errors++;
      $display("CHECK FAILED digest_count expected %0d actual %0d", n_msgs, n_digests);
    end
    $display("Summary: %0d messages, %0d digests presented, %0d errors",
             n_msgs, n_digests, errors);
    if (errors == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+logic
+incdir+tb
logic/sha256_pkg.sv
logic/sha256_msg_ctrl.sv
logic/sha256_schedule.sv
logic/sha256_compress.sv
logic/sha256_engine.sv
tb/tb_sha256.sv
